// ==== dsp_dma_top.f ====
+incdir+logic
logic/dma_reg_pkg.sv
logic/stream_pkg.sv
logic/dma_regs.sv
logic/dma_ctrl.sv
logic/sample_mem.sv
logic/stream_fifo.sv
logic/beat_splitter.sv
logic/beat_packer.sv
logic/dsp_dma_top.sv
tb/tb_clock.sv
tb/dsp_dma_sva.sv
tb/dsp_dma_tb.sv

// ==== logic/beat_packer.sv ====
`timescale 1ns/1ns

module beat_packer (
    input  logic                     m_axis_data,
    input  logic                     rst_n,
    input  stream_pkg::narrow_beat_t beat,
    input  logic                     beat_valid,
    output logic                     beat_pop,
    output logic                     dst_we,
    output logic [63:0]              dst_wdata
);
    logic        half;     // set once the low half is held
    logic [31:0] low_q;

    // the buffer write never stalls, so every beat is taken
    assign beat_pop = beat_valid;

    // =====================================================================
    // pairing state and write strobe
    // =====================================================================
    always_ff @(posedge m_axis_data) begin
        if (!rst_n) begin
            half   <= 1'b0;
            dst_we <= 1'b0;
        end else begin
            dst_we <= beat_pop && half;
            if (beat_pop)
                half <= !half;
        end
    end

    // word data
    always_ff @(posedge m_axis_data) begin
        if (beat_pop && !half)
            low_q <= beat.tdata;
        if (beat_pop && half)
            dst_wdata <= {beat.tdata, low_q};   // high half completes the word
    end

endmodule

// ==== logic/beat_splitter.sv ====
`timescale 1ns/1ns

module beat_splitter (
    input  logic                     m_axis_data,
    input  logic                     rst_n,
    input  stream_pkg::wide_beat_t   word,
    input  logic                     word_valid,
    output logic                     word_pop,
    output stream_pkg::narrow_beat_t dsp_out,
    output logic                     dsp_out_valid,
    input  logic                     dsp_out_ready
);
    logic half;     // 0 = low half on the bus
    logic accept;

    assign dsp_out_valid = word_valid;
    assign accept        = dsp_out_valid && dsp_out_ready;

    assign dsp_out.tdata = half ? word.data[63:32] : word.data[31:0];
    assign dsp_out.tlast = half && word.last;

    // word leaves the FIFO only with its high half
    assign word_pop = accept && half;

    always_ff @(posedge m_axis_data) begin
        if (!rst_n)
            half <= 1'b0;
        else if (accept)
            half <= !half;
    end

endmodule

// ==== logic/dma_ctrl.sv ====
`timescale 1ns/1ns
`include "dsp_dma_config.svh"

module dma_ctrl #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                              m_axis_data,
    input  logic                              rst_n,
    input  dma_reg_pkg::dma_cfg_t             cfg,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]   fifo_count,
    output logic                              src_re,
    output logic [`DMA_AW-1:0]                src_raddr,
    output logic                              src_valid,  // read data valid this cycle
    output logic                              src_last,
    input  logic                              dst_we,
    output logic [`DMA_AW-1:0]                dst_waddr,
    output dma_reg_pkg::dma_status_t          status
);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,     // issuing source reads
        S_DRAIN    // all reads out, waiting on the return path
    } state_e;

    state_e           state;
    logic [`DMA_AW:0] len_q;
    logic [`DMA_AW:0] rd_cnt;
    logic [`DMA_AW:0] wr_cnt;
    logic             done_q;
    logic [CW:0]      fill;
    logic             last_rd;
    logic             last_wr;

    // occupancy as it will be once the read already in flight lands
    assign fill    = {1'b0, fifo_count} + {{CW{1'b0}}, src_valid};
    assign src_re  = (state == S_RUN) && (fill < (CW + 1)'(FIFO_DEPTH));
    assign last_rd = (rd_cnt == len_q - 1'b1);
    assign last_wr = dst_we && (wr_cnt == len_q - 1'b1);

    assign src_raddr = rd_cnt[`DMA_AW-1:0];
    assign dst_waddr = wr_cnt[`DMA_AW-1:0];

    assign status.busy = (state != S_IDLE);
    assign status.done = done_q;

    always_ff @(posedge m_axis_data) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            len_q     <= '0;
            rd_cnt    <= '0;
            wr_cnt    <= '0;
            done_q    <= 1'b0;
            src_valid <= 1'b0;
            src_last  <= 1'b0;
        end else begin
            src_valid <= src_re;
            src_last  <= src_re && last_rd;  // lines up with the RAM output
            case (state)
                S_IDLE: begin
                    if (cfg.start) begin
                        len_q  <= cfg.len;
                        rd_cnt <= '0;
                        wr_cnt <= '0;
                        done_q <= (cfg.len == '0);  // empty run ends at once
                        if (cfg.len != '0)
                            state <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (src_re) begin
                        rd_cnt <= rd_cnt + 1'b1;
                        if (last_rd)
                            state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    if (last_wr) begin
                        state  <= S_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
            if (dst_we && (state != S_IDLE))
                wr_cnt <= wr_cnt + 1'b1;
        end
    end

endmodule

// ==== logic/dma_reg_pkg.sv ====
`include "dsp_dma_config.svh"

package dma_reg_pkg;

    // one cycle of the host strobe bus
    // addr[7] picks the buffer window, low bits index a register or word
    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [7:0]  addr;
        logic [63:0] wdata;
    } host_req_t;

    // register window map
    typedef enum logic [6:0] {
        REG_ID     = 7'd0,
        REG_CTRL   = 7'd1,
        REG_LEN    = 7'd2,
        REG_STATUS = 7'd3
    } reg_addr_e;

    typedef struct packed {
        logic              start;  // single-cycle pulse
        logic [`DMA_AW:0]  len;    // word count, 0..DMA_DEPTH
    } dma_cfg_t;

    typedef struct packed {
        logic busy;
        logic done;
    } dma_status_t;

endpackage

// ==== logic/dma_regs.sv ====
`timescale 1ns/1ns
`include "dsp_dma_config.svh"

module dma_regs (
    input  logic                      m_axis_data,
    input  logic                      rst_n,
    input  dma_reg_pkg::host_req_t    host,
    input  dma_reg_pkg::dma_status_t  status,
    input  logic [63:0]               dst_rdata,
    output dma_reg_pkg::dma_cfg_t     cfg,
    output logic                      src_we,
    output logic [`DMA_AW-1:0]        src_waddr,
    output logic [63:0]               src_wdata,
    output logic [`DMA_AW-1:0]        dst_raddr,
    output logic                      dst_re,
    output logic [63:0]               host_rdata,
    output logic                      host_rvalid
);
    import dma_reg_pkg::*;

    localparam int LW = `DMA_AW + 1;

    logic          win;          // 1 = buffer window
    reg_addr_e     idx;
    logic          reg_wr;
    logic          start_q;
    logic [LW-1:0] len_q;
    logic [63:0]   reg_mux;
    logic [63:0]   reg_rdata_q;
    logic          rd_win_q;     // which source feeds the pending read

    assign win    = host.addr[7];
    assign idx    = reg_addr_e'(host.addr[6:0]);
    assign reg_wr = host.wr && !win;

    // source buffer fill, frozen while a transfer runs
    assign src_we    = host.wr && win && !status.busy;
    assign src_waddr = host.addr[`DMA_AW-1:0];
    assign src_wdata = host.wdata;

    // destination buffer readout, data returns from the RAM next cycle
    assign dst_re    = host.rd && win;
    assign dst_raddr = host.addr[`DMA_AW-1:0];

    assign cfg.start = start_q;
    assign cfg.len   = len_q;

    always_comb begin
        case (idx)
            REG_ID:     reg_mux = 64'(`DMA_ID);
            REG_LEN:    reg_mux = 64'(len_q);
            REG_STATUS: reg_mux = {62'd0, status.done, status.busy};
            default:    reg_mux = '0;   // CTRL reads back as zero
        endcase
    end

    always_ff @(posedge m_axis_data) begin
        if (!rst_n) begin
            start_q     <= 1'b0;
            len_q       <= '0;
            host_rvalid <= 1'b0;
            rd_win_q    <= 1'b0;
        end else begin
            start_q     <= reg_wr && (idx == REG_CTRL) && host.wdata[0];
            host_rvalid <= host.rd;
            if (host.rd)
                rd_win_q <= win;
            if (reg_wr && (idx == REG_LEN)) begin
                // clip oversized counts to one full buffer
                len_q <= (host.wdata > 64'(`DMA_DEPTH)) ? LW'(`DMA_DEPTH)
                                                        : host.wdata[LW-1:0];
            end
        end
    end

    always_ff @(posedge m_axis_data) begin
        if (host.rd)
            reg_rdata_q <= reg_mux;
    end

    assign host_rdata = rd_win_q ? dst_rdata : reg_rdata_q;

endmodule

// ==== logic/dsp_dma_config.svh ====
`ifndef DSP_DMA_CONFIG_SVH
`define DSP_DMA_CONFIG_SVH

// =========================================================================
// buffer geometry
// =========================================================================
`define DMA_DEPTH 64        // 64-bit words per buffer
`define DMA_AW    6         // word address width for DMA_DEPTH

// =========================================================================
// identification
// =========================================================================
`define DMA_ID    16'h5d3a  // returned by the ID register

`endif

// ==== logic/dsp_dma_top.sv ====
`timescale 1ns/1ns
`include "dsp_dma_config.svh"

module dsp_dma_top (
    input  logic                     m_axis_data,
    input  logic                     rst_n,
    input  dma_reg_pkg::host_req_t   host,
    output logic [63:0]              host_rdata,
    output logic                     host_rvalid,
    output stream_pkg::narrow_beat_t dsp_out,
    output logic                     dsp_out_valid,
    input  logic                     dsp_out_ready,
    input  stream_pkg::narrow_beat_t dsp_in,
    input  logic                     dsp_in_valid,
    output logic                     dsp_in_ready
);
    import dma_reg_pkg::*;
    import stream_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int CW         = $clog2(FIFO_DEPTH + 1);

    dma_cfg_t          cfg;
    dma_status_t       status;
    logic              src_we;
    logic [`DMA_AW-1:0] src_waddr;
    logic [63:0]       src_wdata;
    logic              src_re;
    logic [`DMA_AW-1:0] src_raddr;
    logic [63:0]       src_rdata;
    logic              src_valid;
    logic              src_last;
    wide_beat_t        src_beat;
    logic              dst_re;
    logic [`DMA_AW-1:0] dst_raddr;
    logic [63:0]       dst_rdata;
    logic              dst_we;
    logic [`DMA_AW-1:0] dst_waddr;
    logic [63:0]       dst_wdata;
    logic [CW-1:0]     fifo_count;
    wide_beat_t        out_word;
    logic              out_word_valid;
    logic              out_word_pop;
    narrow_beat_t      ret_beat;
    logic              ret_valid;
    logic              ret_pop;

    assign src_beat.data = src_rdata;
    assign src_beat.last = src_last;

    // =====================================================================
    // host side and control
    // =====================================================================
    dma_regs u_regs (
        .m_axis_data (m_axis_data), .rst_n (rst_n),
        .host (host), .status (status), .dst_rdata (dst_rdata), .cfg (cfg),
        .src_we (src_we), .src_waddr (src_waddr), .src_wdata (src_wdata),
        .dst_raddr (dst_raddr), .dst_re (dst_re),
        .host_rdata (host_rdata), .host_rvalid (host_rvalid)
    );

    dma_ctrl #(.FIFO_DEPTH (FIFO_DEPTH)) u_ctrl (
        .m_axis_data (m_axis_data), .rst_n (rst_n), .cfg (cfg),
        .fifo_count (fifo_count), .src_re (src_re), .src_raddr (src_raddr),
        .src_valid (src_valid), .src_last (src_last), .dst_we (dst_we),
        .dst_waddr (dst_waddr), .status (status)
    );

    // =====================================================================
    // buffers and stream datapath
    // =====================================================================
    sample_mem #(.DEPTH (`DMA_DEPTH)) src_mem (
        .m_axis_data (m_axis_data), .we (src_we), .waddr (src_waddr),
        .wdata (src_wdata), .re (src_re), .raddr (src_raddr), .rdata (src_rdata)
    );

    sample_mem #(.DEPTH (`DMA_DEPTH)) dst_mem (
        .m_axis_data (m_axis_data), .we (dst_we), .waddr (dst_waddr),
        .wdata (dst_wdata), .re (dst_re), .raddr (dst_raddr), .rdata (dst_rdata)
    );

    // room is checked by the controller, in_ready left open
    stream_fifo #(.payload_t (wide_beat_t), .DEPTH (FIFO_DEPTH)) out_fifo (
        .m_axis_data (m_axis_data), .rst_n (rst_n),
        .in_data (src_beat), .in_valid (src_valid), .in_ready (),
        .out_data (out_word), .out_valid (out_word_valid),
        .out_ready (out_word_pop), .count (fifo_count)
    );

    beat_splitter u_split (
        .m_axis_data (m_axis_data), .rst_n (rst_n),
        .word (out_word), .word_valid (out_word_valid), .word_pop (out_word_pop),
        .dsp_out (dsp_out), .dsp_out_valid (dsp_out_valid),
        .dsp_out_ready (dsp_out_ready)
    );

    stream_fifo #(.payload_t (narrow_beat_t), .DEPTH (FIFO_DEPTH)) ret_fifo (
        .m_axis_data (m_axis_data), .rst_n (rst_n),
        .in_data (dsp_in), .in_valid (dsp_in_valid), .in_ready (dsp_in_ready),
        .out_data (ret_beat), .out_valid (ret_valid),
        .out_ready (ret_pop), .count ()
    );

    beat_packer u_pack (
        .m_axis_data (m_axis_data), .rst_n (rst_n),
        .beat (ret_beat), .beat_valid (ret_valid), .beat_pop (ret_pop),
        .dst_we (dst_we), .dst_wdata (dst_wdata)
    );

endmodule

// ==== logic/sample_mem.sv ====
`timescale 1ns/1ns

module sample_mem #(
    parameter int DEPTH = 64
) (
    input  logic                      m_axis_data,
    input  logic                      we,
    input  logic [$clog2(DEPTH)-1:0]  waddr,
    input  logic [63:0]               wdata,
    input  logic                      re,
    input  logic [$clog2(DEPTH)-1:0]  raddr,
    output logic [63:0]               rdata
);
    logic [63:0] mem [DEPTH];

    always_ff @(posedge m_axis_data) begin
        if (we)
            mem[waddr] <= wdata;
        if (re)
            rdata <= mem[raddr];   // one cycle read, holds between reads
    end

endmodule

// ==== logic/stream_fifo.sv ====
`timescale 1ns/1ns

module stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic                          m_axis_data,
    input  logic                          rst_n,
    input  payload_t                      in_data,
    input  logic                          in_valid,
    output logic                          in_ready,
    output payload_t                      out_data,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [$clog2(DEPTH+1)-1:0]    count
);
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [CW-1:0] FULL = CW'(DEPTH);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic          push;
    logic          pop;

    assign in_ready  = (count != FULL);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];     // fall-through head
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge m_axis_data) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge m_axis_data) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

// ==== logic/stream_pkg.sv ====
package stream_pkg;

    // =====================================================================
    // 64-bit side, between the source buffer and the splitter
    // =====================================================================
    typedef struct packed {
        logic [63:0] data;
        logic        last;    // final word of the transfer
    } wide_beat_t;

    // =====================================================================
    // 32-bit side, the DSP stream in both directions
    // =====================================================================
    typedef struct packed {
        logic [31:0] tdata;
        logic        tlast;   // high half of the final word
    } narrow_beat_t;

endpackage

// ==== tb/dsp_dma_sva.sv ====
`timescale 1ns/1ns

module dsp_dma_sva (
    input logic                      m_axis_data,
    input logic                      rst_n,
    input dma_reg_pkg::host_req_t    host,
    input logic                      host_rvalid,
    input stream_pkg::narrow_beat_t  dsp_out,
    input logic                      dsp_out_valid,
    input logic                      dsp_out_ready,
    input dma_reg_pkg::dma_status_t  status
);
    // =========================================================================
    // outgoing stream
    // =========================================================================
    property out_beat_held;
        @(posedge m_axis_data) disable iff (!rst_n)
            dsp_out_valid && !dsp_out_ready |=> dsp_out_valid && $stable(dsp_out);
    endproperty

    a_out_beat_held: assert property (out_beat_held)
        else $error("outgoing beat changed or was withdrawn before acceptance");

    // =========================================================================
    // host bus and status
    // =========================================================================
    property rvalid_after_rd;
        @(posedge m_axis_data) disable iff (!rst_n)
            host.rd |=> host_rvalid;
    endproperty

    property no_rvalid_without_rd;
        @(posedge m_axis_data) disable iff (!rst_n)
            !host.rd |=> !host_rvalid;
    endproperty

    a_rvalid_after_rd: assert property (rvalid_after_rd)
        else $error("host_rvalid missing one cycle after a read strobe");

    a_no_rvalid_without_rd: assert property (no_rvalid_without_rd)
        else $error("host_rvalid raised without a read strobe");

    a_busy_done_exclusive: assert property (
        @(posedge m_axis_data) disable iff (!rst_n) !(status.busy && status.done))
        else $error("busy and done both high");

endmodule

// ==== tb/dsp_dma_tb.sv ====
`timescale 1ns/1ns
`include "dsp_dma_config.svh"

module dsp_dma_tb;
    import dma_reg_pkg::*;
    import stream_pkg::*;

    localparam int TOTAL_WORDS     = 8 + `DMA_DEPTH + `DMA_DEPTH + 16 + 5;
    localparam int CYCLES_PER_WORD = 40;

    logic         m_axis_data;
    logic         rst_n;
    host_req_t    host;
    logic [63:0]  host_rdata;
    logic         host_rvalid;
    narrow_beat_t dsp_out;
    logic         dsp_out_valid;
    logic         dsp_out_ready;
    narrow_beat_t dsp_in;
    logic         dsp_in_valid;
    logic         dsp_in_ready;

    integer       seed        = 32'hc592;
    int           errors      = 0;
    int           checks      = 0;
    string        test_name   = "reset";
    bit           random_mode = 1'b0;   // stalls on both streams
    bit           in_taken    = 1'b0;
    logic [63:0]  src_model [`DMA_DEPTH];
    narrow_beat_t exp_beats [$];        // beats the DUT should send next
    narrow_beat_t ret_q [$];            // DSP results not yet returned

    tb_clock u_clock (.m_axis_data (m_axis_data), .rst_n (rst_n));

    dsp_dma_top DUT (
        .m_axis_data (m_axis_data), .rst_n (rst_n), .host (host),
        .host_rdata (host_rdata), .host_rvalid (host_rvalid),
        .dsp_out (dsp_out), .dsp_out_valid (dsp_out_valid),
        .dsp_out_ready (dsp_out_ready), .dsp_in (dsp_in),
        .dsp_in_valid (dsp_in_valid), .dsp_in_ready (dsp_in_ready)
    );

    bind dsp_dma_top dsp_dma_sva u_sva (
        .m_axis_data (m_axis_data), .rst_n (rst_n), .host (host),
        .host_rvalid (host_rvalid), .dsp_out (dsp_out),
        .dsp_out_valid (dsp_out_valid), .dsp_out_ready (dsp_out_ready),
        .status (status)
    );

    // expected destination word with each half incremented on its own
    function automatic logic [63:0] ref_word(input logic [63:0] src);
        ref_word = {src[63:32] + 32'd1, src[31:0] + 32'd1};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // =========================================================================
    // host bus tasks that enter and leave 1 ns after a rising edge
    // =========================================================================
    task automatic host_write(input logic [7:0] addr, input logic [63:0] data);
        host.wr    = 1'b1;
        host.addr  = addr;
        host.wdata = data;
        @(posedge m_axis_data);
        #1;
        host.wr = 1'b0;
    endtask

    task automatic host_read(input logic [7:0] addr, output logic [63:0] data);
        host.rd   = 1'b1;
        host.addr = addr;
        @(posedge m_axis_data);
        #1;
        host.rd = 1'b0;
        check_value({test_name, " rvalid"}, 64'd1, 64'(host_rvalid));
        data = host_rdata;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge m_axis_data);
        #1;
    endtask

    task automatic fill_source(input int words);
        logic [63:0] data;
        for (int i = 0; i < words; i++) begin
            data = {$random(seed), $random(seed)};
            src_model[i] = data;
            host_write({1'b1, 7'(i)}, data);
        end
    endtask

    task automatic start_transfer(input int words);
        for (int i = 0; i < words; i++) begin
            exp_beats.push_back({src_model[i][31:0], 1'b0});
            exp_beats.push_back({src_model[i][63:32], i == words - 1});
        end
        host_write({1'b0, REG_CTRL}, 64'd1);
        idle(1);    // controller has seen the start
    endtask

    task automatic wait_done(input int words);
        logic [63:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < words * CYCLES_PER_WORD) begin
            host_read({1'b0, REG_STATUS}, st);
            polls++;
        end
        if (!st[1]) begin
            errors++;
            $display("%s: transfer of %0d words never raised done", test_name, words);
        end
        check_value({test_name, " beats left"}, 64'd0, 64'(exp_beats.size()));
    endtask

    task automatic check_dest(input int words);
        logic [63:0] data;
        for (int i = 0; i < words; i++) begin
            host_read({1'b1, 7'(i)}, data);
            check_value($sformatf("%s dst[%0d]", test_name, i), ref_word(src_model[i]), data);
        end
    endtask

    // =========================================================================
    // DSP loopback with handshakes sampled mid-cycle
    // =========================================================================
    always @(negedge m_axis_data) begin
        if (rst_n && dsp_out_valid && dsp_out_ready)
            ret_q.push_back({dsp_out.tdata + 32'd1, dsp_out.tlast});
        if (rst_n && dsp_in_valid && dsp_in_ready)
            in_taken = 1'b1;
    end

    always @(posedge m_axis_data) begin
        #1;
        if (!rst_n) begin
            dsp_out_ready = 1'b0;
            dsp_in_valid  = 1'b0;
        end else begin
            dsp_out_ready = random_mode ? (($random(seed) & 3) != 0) : 1'b1;
            if (in_taken) begin
                dsp_in_valid = 1'b0;
                in_taken     = 1'b0;
            end
            if (!dsp_in_valid && ret_q.size() != 0
                    && (!random_mode || ($random(seed) & 3) != 0)) begin
                dsp_in       = ret_q.pop_front();
                dsp_in_valid = 1'b1;
            end
        end
    end

    // compare each accepted outgoing beat against the source snapshot
    always @(negedge m_axis_data) begin
        if (rst_n && dsp_out_valid && dsp_out_ready) begin
            if (exp_beats.size() == 0) begin
                errors++;
                $display("%s: DUT sent a beat when none was expected", test_name);
            end else begin
                check_value({test_name, " tdata"}, 64'(exp_beats[0].tdata),
                            64'(dsp_out.tdata));
                check_value({test_name, " tlast"}, 64'(exp_beats[0].tlast),
                            64'(dsp_out.tlast));
                void'(exp_beats.pop_front());
            end
        end
    end

    initial begin
        repeat (TOTAL_WORDS * CYCLES_PER_WORD) @(posedge m_axis_data);
        $display("watchdog expired after %0d cycles, errors so far %0d",
                 TOTAL_WORDS * CYCLES_PER_WORD, errors);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [63:0] rd;
        host          = '0;
        dsp_out_ready = 1'b0;
        dsp_in        = '0;
        dsp_in_valid  = 1'b0;
        @(posedge rst_n);

        // ID, idle status and read timing
        idle(1);
        check_value("reset rvalid idle", 64'd0, 64'(host_rvalid));
        check_value("reset out_valid", 64'd0, 64'(dsp_out_valid));
        check_value("reset in_ready", 64'd1, 64'(dsp_in_ready));
        host_read({1'b0, REG_ID}, rd);
        check_value("reset id", 64'(`DMA_ID), rd);
        idle(1);
        check_value("reset rvalid after id", 64'd0, 64'(host_rvalid));
        host_read({1'b0, REG_STATUS}, rd);
        check_value("reset status", 64'd0, rd);
        idle(1);
        check_value("reset rvalid after status", 64'd0, 64'(host_rvalid));

        test_name = "short";
        fill_source(8);
        host_write({1'b0, REG_LEN}, 64'd8);
        start_transfer(8);
        wait_done(8);
        check_dest(8);

        test_name   = "full";
        random_mode = 1'b1;
        fill_source(`DMA_DEPTH);
        host_write({1'b0, REG_LEN}, 64'(`DMA_DEPTH));
        start_transfer(`DMA_DEPTH);
        wait_done(`DMA_DEPTH);
        check_dest(`DMA_DEPTH);

        test_name   = "clip";
        random_mode = 1'b0;
        fill_source(`DMA_DEPTH);
        host_write({1'b0, REG_LEN}, 64'd200);
        host_read({1'b0, REG_LEN}, rd);
        check_value("clip len", 64'(`DMA_DEPTH), rd);
        start_transfer(`DMA_DEPTH);
        wait_done(`DMA_DEPTH);
        check_dest(`DMA_DEPTH);

        // restart and source write while busy are both dropped
        test_name   = "busy";
        random_mode = 1'b1;
        fill_source(16);
        host_write({1'b0, REG_LEN}, 64'd16);
        start_transfer(16);
        host_read({1'b0, REG_STATUS}, rd);
        check_value("busy status running", 64'd1, rd);
        host_write({1'b0, REG_CTRL}, 64'd1);
        host_write({1'b1, 7'd15}, ~src_model[15]);
        wait_done(16);
        host_read({1'b0, REG_STATUS}, rd);
        check_value("busy status ended", 64'd2, rd);
        host_read({1'b0, REG_LEN}, rd);
        check_value("busy len", 64'd16, rd);
        check_dest(16);

        test_name = "rerun";
        fill_source(5);
        host_write({1'b0, REG_LEN}, 64'd5);
        start_transfer(5);
        host_read({1'b0, REG_STATUS}, rd);
        check_value("rerun status cleared", 64'd1, rd);   // busy with done dropped
        wait_done(5);
        check_dest(5);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 5
) (
    output logic m_axis_data,
    output logic rst_n
);
    initial begin
        m_axis_data = 1'b0;
        forever #HALF_PERIOD m_axis_data = !m_axis_data;
    end

    // synchronous reset, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge m_axis_data);
        #1 rst_n = 1'b1;
    end

endmodule
